/* mipsSystem.f */
+incdir+common
common/mipsPkg.sv
logic/alu.sv
logic/instrDecoder.sv
core/fetchUnit.sv
core/regFile.sv
core/mipsCore.sv
logic/apbDebug.sv
logic/mipsSystem.sv
bench/mipsChecker.sv
bench/mipsSystemTb.sv

/* bench/mipsSystemTb.sv */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mipsSystemTb;

localparam logic [11:0] imemBase = `MIPS_ADDR_IMEM;
localparam logic [11:0] regsBase = `MIPS_ADDR_REGS;
localparam logic [11:0] r3Addr = `MIPS_ADDR_REGS + 12'd12;
localparam logic [11:0] pcAddr = `MIPS_ADDR_PC;
localparam logic [11:0] stepAddr = `MIPS_ADDR_STEP;
localparam logic [11:0] statusAddr = `MIPS_ADDR_STATUS;
localparam logic [11:0] dmemBase = `MIPS_ADDR_DMEM;

typedef struct packed
{
	logic [3:0][31:0] prog;
	logic [31:0] rsVal; // Preset for r1
	logic [31:0] rtVal; // Preset for r2
	logic [7:0] steps;
	logic [11:0] addr;
	logic [31:0] expVal;
} rowT;

logic clk, rst;
logic [`MIPS_APB_AW-1:0] paddr;
logic psel, penable, pwrite;
logic [31:0] pwdata, prdata;
logic pready, pslverr;
rowT rows[$];
string rowNames[$];
integer seed;
logic aborted;

mipsSystem mipsSystem_inst (.clk(clk), .rst(rst), .paddr(paddr), .psel(psel),
	.penable(penable), .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata),
	.pready(pready), .pslverr(pslverr));

mipsChecker mipsChecker_inst (.clk(clk), .rst(rst), .psel(psel), .penable(penable),
	.pwrite(pwrite), .pready(pready), .prdata(prdata), .pslverr(pslverr));

initial
begin
	clk = 1'b0;
	forever #10 clk = ~clk;
end

function automatic logic [31:0] rType(input logic [5:0] funct, input logic [4:0] rd,
	input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] shamt);
	return {6'b000000, rs, rt, rd, shamt, funct};
endfunction

function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
	input logic [4:0] rt, input logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

// Reference results for the randomized rows
function automatic logic [31:0] aluModel(input logic [5:0] funct, input logic [31:0] a,
	input logic [31:0] b);
	case (funct)
		6'h20: return a + b;
		6'h22: return a - b;
		6'h2a: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		6'h2b: return (a < b) ? 32'd1 : 32'd0;
		default: return 32'd0;
	endcase
endfunction

task addRow(input string name, input logic [31:0] w0, input logic [31:0] w1,
	input logic [31:0] rsVal, input logic [31:0] rtVal, input logic [7:0] steps,
	input logic [11:0] addr, input logic [31:0] expVal);
	rowT row;
	row.prog = {32'h0, 32'h0, w1, w0}; // Unused words are NOPs
	row.rsVal = rsVal;
	row.rtVal = rtVal;
	row.steps = steps;
	row.addr = addr;
	row.expVal = expVal;
	rows.push_back(row);
	rowNames.push_back(name);
endtask

task addRandomRow(input string name, input logic [5:0] funct);
	logic [31:0] a;
	logic [31:0] b;
	a = $random(seed);
	b = $random(seed);
	addRow(name, rType(funct, 3, 1, 2, 0), 32'h0, a, b, 8'd1, r3Addr, aluModel(funct, a, b));
endtask

task buildTable();
	addRow("reset r7", 0, 0, 0, 0, 8'd0, regsBase + 12'd28, 32'd7);
	addRow("reset r31", 0, 0, 0, 0, 8'd0, regsBase + 12'd124, 32'd31);
	addRow("reset r0", 0, 0, 0, 0, 8'd0, regsBase, 32'd0);
	addRow("reset pc", 0, 0, 0, 0, 8'd0, pcAddr, 32'd0);
	addRow("reset status", 0, 0, 0, 0, 8'd0, statusAddr, 32'd0);
	addRow("reset dmem", 0, 0, 0, 0, 8'd0, dmemBase + 12'd5, 32'd0);
	addRow("add", rType(6'h20, 3, 1, 2, 0), 0, 32'd100, 32'hFFFF_FFE2, 8'd1, r3Addr, 32'd70);
	addRow("sub", rType(6'h22, 3, 1, 2, 0), 0, 32'd5, 32'd9, 8'd1, r3Addr, 32'hFFFF_FFFC);
	addRow("and", rType(6'h24, 3, 1, 2, 0), 0, 32'hF0F0_1234, 32'h0FF0_FF00, 8'd1,
		r3Addr, 32'h00F0_1200);
	addRow("or", rType(6'h25, 3, 1, 2, 0), 0, 32'hF0F0_1234, 32'h0FF0_FF00, 8'd1,
		r3Addr, 32'hFFF0_FF34);
	addRow("nor", rType(6'h27, 3, 1, 2, 0), 0, 32'hF0F0_1234, 32'h0FF0_FF00, 8'd1,
		r3Addr, 32'h000F_00CB);
	addRow("xor", rType(6'h26, 3, 1, 2, 0), 0, 32'hF0F0_1234, 32'h0FF0_FF00, 8'd1,
		r3Addr, 32'hFF00_ED34);
	addRow("slt signed", rType(6'h2a, 3, 1, 2, 0), 0, 32'hFFFF_FFFF, 32'd1, 8'd1, r3Addr, 32'd1);
	addRow("sltu unsigned", rType(6'h2b, 3, 1, 2, 0), 0, 32'hFFFF_FFFF, 32'd1, 8'd1,
		r3Addr, 32'd0);
	addRow("sll", rType(6'h00, 3, 0, 2, 4), 0, 32'h1F, 32'hF1, 8'd1, r3Addr, 32'hF10);
	addRow("srl", rType(6'h02, 3, 0, 2, 4), 0, 32'h1F, 32'h8000_0000, 8'd1, r3Addr, 32'h0800_0000);
	addRow("sra", rType(6'h03, 3, 0, 2, 4), 0, 32'h1F, 32'h8000_0000, 8'd1, r3Addr, 32'hF800_0000);
	addRow("sllv", rType(6'h04, 3, 1, 2, 0), 0, 32'd3, 32'd5, 8'd1, r3Addr, 32'd40);
	addRow("srlv", rType(6'h06, 3, 1, 2, 0), 0, 32'd36, 32'h8000_0000, 8'd1, r3Addr, 32'h0800_0000);
	addRow("srav", rType(6'h07, 3, 1, 2, 0), 0, 32'd8, 32'h8000_0000, 8'd1, r3Addr, 32'hFF80_0000);
	addRow("write r0", rType(6'h20, 0, 1, 2, 0), 0, 32'd5, 32'd6, 8'd1, regsBase, 32'd0);
	addRandomRow("random add", 6'h20);
	addRandomRow("random sub", 6'h22);
	addRandomRow("random slt", 6'h2a);
	addRandomRow("random sltu", 6'h2b);
	addRow("addi", iType(6'h08, 1, 3, 16'hFFFE), 0, 32'd10, 0, 8'd1, r3Addr, 32'd8);
	addRow("slti", iType(6'h0a, 1, 3, 16'hFFFD), 0, 32'hFFFF_FFFB, 0, 8'd1, r3Addr, 32'd1);
	addRow("slti sign extend", iType(6'h0a, 1, 3, 16'hFFFD), 0, 32'd5, 0, 8'd1, r3Addr, 32'd0);
	addRow("andi", iType(6'h0c, 1, 3, 16'h8001), 0, 32'hFFFF_FFFF, 0, 8'd1, r3Addr, 32'h8001);
	addRow("ori", iType(6'h0d, 1, 3, 16'h8000), 0, 32'h1234_0000, 0, 8'd1, r3Addr, 32'h1234_8000);
	addRow("xori", iType(6'h0e, 1, 3, 16'hFFFF), 0, 32'hFFFF_0000, 0, 8'd1, r3Addr, 32'hFFFF_FFFF);
	addRow("sb lb negative", iType(6'h28, 1, 2, 16'd4), iType(6'h20, 1, 3, 16'd4), 32'h10,
		32'h1234_5680, 8'd2, r3Addr, 32'hFFFF_FF80);
	addRow("sb dmem byte", iType(6'h28, 1, 2, 16'd4), iType(6'h20, 1, 3, 16'd4), 32'h10,
		32'h1234_5680, 8'd2, dmemBase + 12'h14, 32'h80);
	addRow("sb lb positive", iType(6'h28, 1, 2, 16'd4), iType(6'h20, 1, 3, 16'd4), 32'h10,
		32'h0000_017F, 8'd2, r3Addr, 32'h7F);
	addRow("beq taken", iType(6'h04, 1, 2, 16'd3), 0, 32'd7, 32'd7, 8'd1, pcAddr, 32'd16);
	addRow("beq not taken", iType(6'h04, 1, 2, 16'd3), 0, 32'd1, 32'd2, 8'd1, pcAddr, 32'd4);
	addRow("bne taken", iType(6'h05, 1, 2, 16'd5), 0, 32'd1, 32'd2, 8'd1, pcAddr, 32'd24);
	addRow("bne not taken", iType(6'h05, 1, 2, 16'd5), 0, 32'd7, 32'd7, 8'd1, pcAddr, 32'd4);
	addRow("beq backward", iType(6'h04, 1, 2, 16'hFFFF), 0, 32'd7, 32'd7, 8'd1, pcAddr, 32'd0);
	addRow("j", {6'h02, 26'h10}, 0, 0, 0, 8'd1, pcAddr, 32'h40);
endtask

// Starts and returns 2 ns after a rising edge
task apbTransfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
	output logic [31:0] rdata);
	int waitCount;
	rdata = '0;
	if (!aborted)
	begin
		paddr = addr;
		pwrite = wr;
		pwdata = wdata;
		psel = 1'b1;
		penable = 1'b0;
		@(posedge clk);
		#2;
		penable = 1'b1; // Access phase
		@(negedge clk);
		waitCount = 0;
		while (pready !== 1'b1 && waitCount < 16)
		begin
			@(negedge clk);
			waitCount++;
		end
		if (pready !== 1'b1)
		begin
			mipsChecker_inst.noteFailure($sformatf("no pready for transfer to 0x%03h", addr));
			aborted = 1'b1;
		end
		rdata = prdata;
		@(posedge clk);
		#2;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	end
endtask

task apbWrite(input logic [11:0] addr, input logic [31:0] data);
	logic [31:0] unused;
	apbTransfer(1'b1, addr, data, unused);
endtask

task apbRead(input logic [11:0] addr, output logic [31:0] data);
	apbTransfer(1'b0, addr, 32'h0, data);
endtask

task resetDut();
	rst = 1'b1;
	repeat (8) @(posedge clk);
	#2;
	rst = 1'b0;
endtask

task waitIdle(input string name, input int limit);
	logic [31:0] status;
	int polls;
	polls = 0;
	status = 32'd1;
	while (status[0] !== 1'b0 && polls < limit && !aborted)
	begin
		apbRead(statusAddr, status);
		polls++;
	end
	if (!aborted && status[0] !== 1'b0)
	begin
		mipsChecker_inst.noteFailure($sformatf("%s: core still busy after %0d polls", name, polls));
		aborted = 1'b1;
	end
endtask

task runRow(input int idx);
	rowT row;
	logic [31:0] data;
	row = rows[idx];
	resetDut();
	for (int w = 0; w < 4; w++)
		apbWrite(imemBase + 12'(4 * w), row.prog[w]);
	apbWrite(regsBase + 12'd4, row.rsVal);
	apbWrite(regsBase + 12'd8, row.rtVal);
	apbWrite(stepAddr, 32'(row.steps));
	waitIdle(rowNames[idx], int'(row.steps) + 8);
	mipsChecker_inst.expectRead(rowNames[idx], row.expVal);
	apbRead(row.addr, data);
endtask

task busyAndErrorChecks();
	logic [31:0] data;
	resetDut();
	apbWrite(imemBase, iType(6'h08, 0, 3, 16'h0055)); // ADDI r3, r0, 0x55
	apbWrite(imemBase + 12'd4, {6'h02, 26'h0}); // J 0 keeps the core looping
	apbWrite(stepAddr, 32'd20);
	mipsChecker_inst.expectRead("status busy", 32'd1);
	apbRead(statusAddr, data);
	mipsChecker_inst.expectError("imem write while busy");
	apbWrite(imemBase, iType(6'h08, 0, 3, 16'h0066));
	waitIdle("imem write while busy", 30);
	apbWrite(r3Addr, 32'd0);
	apbWrite(pcAddr, 32'd0);
	apbWrite(stepAddr, 32'd1);
	waitIdle("imem unchanged", 10);
	mipsChecker_inst.expectRead("imem unchanged", 32'h55); // Old ADDI still in word 0
	apbRead(r3Addr, data);
	mipsChecker_inst.expectError("unmapped read 0x28c");
	apbRead(12'h28C, data);
	mipsChecker_inst.expectError("unmapped read 0x380");
	apbRead(12'h380, data);
endtask

initial
begin
	rst = 1'b1;
	paddr = '0;
	psel = 1'b0;
	penable = 1'b0;
	pwrite = 1'b0;
	pwdata = '0;
	aborted = 1'b0;
	seed = 51;
	buildTable();
	@(posedge clk);
	#2;
	for (int i = 0; i < rows.size(); i++)
	begin
		if (!aborted)
			runRow(i);
	end
	if (!aborted)
		busyAndErrorChecks();
	$display("Transfers: %0d, mismatches: %0d, other failures: %0d",
		mipsChecker_inst.transferCount, mipsChecker_inst.mismatchCount,
		mipsChecker_inst.failureCount);
	if (mipsChecker_inst.mismatchCount == 0 && mipsChecker_inst.failureCount == 0)
		$display("NO ERRORS");
	else
		$display("ERRORS FOUND");
	$finish;
end

endmodule

/* bench/mipsChecker.sv */
`timescale 1ns/1ps

module mipsChecker (
	input logic clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic pready,
	input logic [31:0] prdata,
	input logic pslverr
);

string expName;
logic checkData;
logic [31:0] expData;
logic expErr;
int transferCount;
int mismatchCount;
int failureCount;

initial
begin
	expName = "apb transfer";
	checkData = 1'b0;
	expData = '0;
	expErr = 1'b0;
	transferCount = 0;
	mismatchCount = 0;
	failureCount = 0;
end

// Armed for the next transfer only
task expectRead(input string name, input logic [31:0] value);
	expName = name;
	checkData = 1'b1;
	expData = value;
	expErr = 1'b0;
endtask

task expectError(input string name);
	expName = name;
	checkData = 1'b0;
	expErr = 1'b1;
endtask

task noteFailure(input string msg);
	failureCount++;
	$display("FAILURE: %s", msg);
endtask

// Mid-cycle of the access phase, prdata and pslverr are settled
always @(negedge clk)
begin
	if (!rst && psel && penable && pready)
	begin
		transferCount++;
		if (pslverr !== expErr)
		begin
			mismatchCount++;
			$display("MISMATCH %s: pslverr expected %0b actual %0b", expName, expErr, pslverr);
		end
		else if (checkData && !pwrite && prdata !== expData)
		begin
			mismatchCount++;
			$display("MISMATCH %s: expected 0x%08h actual 0x%08h", expName, expData, prdata);
		end
		expName = "apb transfer"; // Back to the plain no-error check
		checkData = 1'b0;
		expErr = 1'b0;
	end
end

endmodule

/* logic/mipsSystem.sv */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mipsSystem (
	input logic clk,
	input logic rst,
	input logic [`MIPS_APB_AW-1:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [`MIPS_XLEN-1:0] pwdata,
	output logic [`MIPS_XLEN-1:0] prdata,
	output logic pready,
	output logic pslverr
);

mipsPkg::dbgReqT dbg;
mipsPkg::readSelT readSel;
logic [$clog2(`MIPS_IMEM_WORDS)-1:0] readIndex;
logic [`MIPS_XLEN-1:0] readData;
logic busy;

apbDebug apbDebug_inst (.clk(clk), .rst(rst), .paddr(paddr), .psel(psel),
	.penable(penable), .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata),
	.pready(pready), .pslverr(pslverr), .busy(busy), .dbg(dbg),
	.readSel(readSel), .readIndex(readIndex), .readData(readData));

mipsCore mipsCore_inst (.clk(clk), .rst(rst), .dbg(dbg), .readSel(readSel),
	.readIndex(readIndex), .readData(readData), .busy(busy));

endmodule

/* logic/apbDebug.sv */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module apbDebug (
	input logic clk,
	input logic rst,
	input logic [`MIPS_APB_AW-1:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [`MIPS_XLEN-1:0] pwdata,
	output logic [`MIPS_XLEN-1:0] prdata,
	output logic pready,
	output logic pslverr,
	input logic busy,
	output mipsPkg::dbgReqT dbg,
	output mipsPkg::readSelT readSel,
	output logic [$clog2(`MIPS_IMEM_WORDS)-1:0] readIndex,
	input logic [`MIPS_XLEN-1:0] readData
);

localparam int idxWidth = $clog2(`MIPS_IMEM_WORDS);

logic [`MIPS_APB_AW-1:0] imemOff, regsOff, dmemOff;
logic inImem, inRegs, isPc, isStep, isStatus, inDmem;
logic stateTarget, readable, mapped, setup, wrStrobe;

// Offsets into each window, compares wrap cleanly below the base
assign imemOff = paddr - `MIPS_ADDR_IMEM;
assign regsOff = paddr - `MIPS_ADDR_REGS;
assign dmemOff = paddr - `MIPS_ADDR_DMEM;
assign inImem = imemOff < `MIPS_APB_AW'(4 * `MIPS_IMEM_WORDS);
assign inRegs = regsOff < `MIPS_APB_AW'(4 * `MIPS_REG_COUNT);
assign inDmem = dmemOff < `MIPS_APB_AW'(`MIPS_DMEM_BYTES); // One byte per address
assign isPc = paddr == `MIPS_ADDR_PC;
assign isStep = paddr == `MIPS_ADDR_STEP;
assign isStatus = paddr == `MIPS_ADDR_STATUS;

assign stateTarget = inImem || inRegs || isPc || inDmem;
assign readable = inRegs || isPc || isStatus || inDmem;
assign mapped = stateTarget || isStep || isStatus;
assign setup = psel && !penable;
assign wrStrobe = psel && penable && pwrite && !pslverr; // Errored writes are dropped

always_comb
begin
	if (inImem)
		readIndex = imemOff[idxWidth+1:2];
	else if (inDmem)
		readIndex = dmemOff[idxWidth-1:0];
	else
		readIndex = idxWidth'(regsOff[`MIPS_REG_AW+1:2]);
end

always_comb
begin
	if (isPc)
		readSel = mipsPkg::rdPc;
	else if (inDmem)
		readSel = mipsPkg::rdDmem;
	else if (isStatus)
		readSel = mipsPkg::rdStatus;
	else
		readSel = mipsPkg::rdReg;
end

always_comb
begin
	dbg = '0;
	dbg.index = readIndex; // Same index serves read and write
	dbg.wdata = pwdata;
	dbg.imemWe = wrStrobe && inImem;
	dbg.regWe = wrStrobe && inRegs;
	dbg.pcWe = wrStrobe && isPc;
	dbg.dmemWe = wrStrobe && inDmem;
	dbg.stepStart = wrStrobe && isStep;
end

// Error decided in setup so it is stable through the access phase
always_ff @(posedge clk)
begin
	if (rst)
		pslverr <= 1'b0;
	else
		pslverr <= setup && (!mapped || (pwrite && busy && stateTarget));
end

always_ff @(posedge clk)
begin
	if (setup && !pwrite)
		prdata <= readable ? readData : '0;
end

assign pready = 1'b1; // No wait states

penableNeedsPsel: assert property (@(posedge clk) disable iff (rst) penable |-> psel)
	else $error("apbDebug: penable high without psel");

endmodule

/* core/mipsCore.sv */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mipsCore (
	input logic clk,
	input logic rst,
	input mipsPkg::dbgReqT dbg,
	input mipsPkg::readSelT readSel,
	input logic [$clog2(`MIPS_IMEM_WORDS)-1:0] readIndex,
	output logic [`MIPS_XLEN-1:0] readData,
	output logic busy
);

localparam int dmemAw = $clog2(`MIPS_DMEM_BYTES);

mipsPkg::instrT instr;
mipsPkg::ctrlT ctrl;
logic [`MIPS_XLEN-1:0] pc, rsData, rtData, dbgData;
logic [`MIPS_XLEN-1:0] immExt, opA, opB, aluResult, lbData;
logic [`MIPS_XLEN-1:0] stepCount;
logic [7:0] dmem [`MIPS_DMEM_BYTES];
logic [dmemAw-1:0] dmemAddr;
logic branchTaken, regWe;
logic [`MIPS_REG_AW-1:0] regWAddr;
logic [`MIPS_XLEN-1:0] regWData;

fetchUnit fetchUnit_inst (.clk(clk), .rst(rst), .advance(busy), .branchTaken(branchTaken),
	.branchOffset(instr.i.imm16), .jump(ctrl.jump), .jumpTarget(instr.j.target26),
	.dbg(dbg), .instr(instr), .pc(pc));

instrDecoder instrDecoder_inst (.instr(instr), .ctrl(ctrl));

regFile regFile_inst (.clk(clk), .rst(rst), .rs(ctrl.srcA), .rt(ctrl.srcB),
	.rsData(rsData), .rtData(rtData), .we(regWe), .wAddr(regWAddr), .wData(regWData),
	.dbgIndex(readIndex[`MIPS_REG_AW-1:0]), .dbgData(dbgData));

alu alu_inst (.a(opA), .b(opB), .op(ctrl.aluOp), .result(aluResult));

always_comb
begin
	if (ctrl.useShamt)
		immExt = `MIPS_XLEN'(instr.r.shamt);
	else if (ctrl.immSigned)
		immExt = {{(`MIPS_XLEN-16){instr.i.imm16[15]}}, instr.i.imm16};
	else
		immExt = {{(`MIPS_XLEN-16){1'b0}}, instr.i.imm16};
end

assign opA = ctrl.useShamt ? immExt : rsData; // Shift amount enters on a
assign opB = ctrl.useImm ? immExt : rtData;
assign branchTaken = (ctrl.br == mipsPkg::brEq && rsData == rtData)
	|| (ctrl.br == mipsPkg::brNe && rsData != rtData);

assign dmemAddr = aluResult[dmemAw-1:0];
assign lbData = {{(`MIPS_XLEN-8){dmem[dmemAddr][7]}}, dmem[dmemAddr]};

// Writeback while running, debug port while halted
assign regWe = busy ? ctrl.regWrite : dbg.regWe;
assign regWAddr = busy ? ctrl.dest : dbg.index[`MIPS_REG_AW-1:0];
assign regWData = busy ? (ctrl.memRead ? lbData : aluResult) : dbg.wdata;

always_ff @(posedge clk)
begin
	if (rst)
	begin
		for (int i = 0; i < `MIPS_DMEM_BYTES; i++)
			dmem[i] <= '0;
	end
	else if (busy && ctrl.memWrite)
		dmem[dmemAddr] <= rtData[7:0]; // SB keeps the low byte only
	else if (dbg.dmemWe)
		dmem[dbg.index[dmemAw-1:0]] <= dbg.wdata[7:0];
end

always_ff @(posedge clk)
begin
	if (rst)
	begin
		busy <= 1'b0;
		stepCount <= '0;
	end
	else if (busy)
	begin
		stepCount <= stepCount - 1'b1;
		if (stepCount == `MIPS_XLEN'(1))
			busy <= 1'b0; // Last instruction retires here
	end
	else if (dbg.stepStart && dbg.wdata != '0)
	begin
		busy <= 1'b1;
		stepCount <= dbg.wdata;
	end
end

always_comb
begin
	case (readSel)
		mipsPkg::rdPc: readData = pc;
		mipsPkg::rdDmem: readData = {{(`MIPS_XLEN-8){1'b0}}, dmem[readIndex[dmemAw-1:0]]};
		mipsPkg::rdStatus: readData = {{(`MIPS_XLEN-1){1'b0}}, busy};
		default: readData = dbgData;
	endcase
end

// The APB side has to hold off state writes while instructions run
noDbgWriteBusy: assert property (@(posedge clk) disable iff (rst)
	busy |-> !(dbg.imemWe || dbg.regWe || dbg.pcWe || dbg.dmemWe))
	else $error("mipsCore: debug write while core is busy");

endmodule

/* core/regFile.sv */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module regFile (
	input logic clk,
	input logic rst,
	input logic [`MIPS_REG_AW-1:0] rs,
	input logic [`MIPS_REG_AW-1:0] rt,
	output logic [`MIPS_XLEN-1:0] rsData,
	output logic [`MIPS_XLEN-1:0] rtData,
	input logic we,
	input logic [`MIPS_REG_AW-1:0] wAddr,
	input logic [`MIPS_XLEN-1:0] wData,
	input logic [`MIPS_REG_AW-1:0] dbgIndex,
	output logic [`MIPS_XLEN-1:0] dbgData
);

logic [`MIPS_XLEN-1:0] regs [`MIPS_REG_COUNT];

always_ff @(posedge clk)
begin
	if (rst)
	begin
		for (int i = 0; i < `MIPS_REG_COUNT; i++)
			regs[i] <= `MIPS_XLEN'(i); // Each register starts at its own index
	end
	else if (we)
		regs[wAddr] <= wData;
end

// r0 is hardwired to zero on every port
assign rsData = (rs == '0) ? '0 : regs[rs];
assign rtData = (rt == '0) ? '0 : regs[rt];
assign dbgData = (dbgIndex == '0) ? '0 : regs[dbgIndex];

endmodule

/* core/fetchUnit.sv */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module fetchUnit (
	input logic clk,
	input logic rst,
	input logic advance,
	input logic branchTaken,
	input logic [15:0] branchOffset,
	input logic jump,
	input logic [25:0] jumpTarget,
	input mipsPkg::dbgReqT dbg,
	output mipsPkg::instrT instr,
	output logic [`MIPS_XLEN-1:0] pc
);

localparam int idxWidth = $clog2(`MIPS_IMEM_WORDS);

logic [`MIPS_XLEN-1:0] imem [`MIPS_IMEM_WORDS];
logic [`MIPS_XLEN-1:0] pcPlus4;
logic [`MIPS_XLEN-1:0] branchPc;
logic [`MIPS_XLEN-1:0] nextPc;

assign instr = imem[pc[idxWidth+1:2]]; // Word-indexed fetch
assign pcPlus4 = pc + `MIPS_XLEN'(4);
assign branchPc = pcPlus4 + {{(`MIPS_XLEN-18){branchOffset[15]}}, branchOffset, 2'b00};

always_comb
begin
	if (jump)
		nextPc = {pc[`MIPS_XLEN-1:28], jumpTarget, 2'b00};
	else if (branchTaken)
		nextPc = branchPc;
	else
		nextPc = pcPlus4;
end

always_ff @(posedge clk)
begin
	if (rst)
		pc <= '0;
	else if (dbg.pcWe)
		pc <= dbg.wdata; // Debug load
	else if (advance)
		pc <= nextPc;
end

always_ff @(posedge clk)
begin
	if (dbg.imemWe)
		imem[dbg.index] <= dbg.wdata;
end

pcAligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
	else $error("fetchUnit: PC 0x%08h is not word aligned", pc);

endmodule

/* logic/instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder (
	input mipsPkg::instrT instr,
	output mipsPkg::ctrlT ctrl
);

always_comb
begin
	ctrl = '0; // Unknown words fall through as a no-op
	ctrl.aluOp = mipsPkg::aluAdd;
	ctrl.br = mipsPkg::brNone;
	case (instr.r.opcode)
		mipsPkg::opRtype:
		begin
			ctrl.srcA = instr.r.rs;
			ctrl.srcB = instr.r.rt;
			ctrl.dest = instr.r.rd;
			ctrl.regWrite = 1'b1;
			case (instr.r.funct)
				mipsPkg::fnAdd: ctrl.aluOp = mipsPkg::aluAdd;
				mipsPkg::fnSub: ctrl.aluOp = mipsPkg::aluSub;
				mipsPkg::fnAnd: ctrl.aluOp = mipsPkg::aluAnd;
				mipsPkg::fnOr: ctrl.aluOp = mipsPkg::aluOr;
				mipsPkg::fnNor: ctrl.aluOp = mipsPkg::aluNor;
				mipsPkg::fnXor: ctrl.aluOp = mipsPkg::aluXor;
				mipsPkg::fnSlt: ctrl.aluOp = mipsPkg::aluSlt;
				mipsPkg::fnSltu: ctrl.aluOp = mipsPkg::aluSltu;
				mipsPkg::fnSllv: ctrl.aluOp = mipsPkg::aluSll; // Amount from rs
				mipsPkg::fnSrlv: ctrl.aluOp = mipsPkg::aluSrl;
				mipsPkg::fnSrav: ctrl.aluOp = mipsPkg::aluSra;
				mipsPkg::fnSll:
				begin
					ctrl.aluOp = mipsPkg::aluSll;
					ctrl.useShamt = 1'b1;
				end
				mipsPkg::fnSrl:
				begin
					ctrl.aluOp = mipsPkg::aluSrl;
					ctrl.useShamt = 1'b1;
				end
				mipsPkg::fnSra:
				begin
					ctrl.aluOp = mipsPkg::aluSra;
					ctrl.useShamt = 1'b1;
				end
				default: ctrl.regWrite = 1'b0; // Unknown funct
			endcase
		end
		mipsPkg::opAddi, mipsPkg::opSlti, mipsPkg::opAndi,
		mipsPkg::opOri, mipsPkg::opXori, mipsPkg::opLb:
		begin
			ctrl.srcA = instr.i.rs;
			ctrl.srcB = instr.i.rt;
			ctrl.dest = instr.i.rt; // I-type result goes to rt
			ctrl.regWrite = 1'b1;
			ctrl.useImm = 1'b1;
			ctrl.memRead = instr.i.opcode == mipsPkg::opLb;
			ctrl.immSigned = instr.i.opcode inside
				{mipsPkg::opAddi, mipsPkg::opSlti, mipsPkg::opLb};
			case (instr.i.opcode)
				mipsPkg::opSlti: ctrl.aluOp = mipsPkg::aluSlt;
				mipsPkg::opAndi: ctrl.aluOp = mipsPkg::aluAnd;
				mipsPkg::opOri: ctrl.aluOp = mipsPkg::aluOr;
				mipsPkg::opXori: ctrl.aluOp = mipsPkg::aluXor;
				default: ctrl.aluOp = mipsPkg::aluAdd; // ADDI and LB address
			endcase
		end
		mipsPkg::opSb:
		begin
			ctrl.srcA = instr.i.rs;
			ctrl.srcB = instr.i.rt; // Byte to store
			ctrl.useImm = 1'b1;
			ctrl.immSigned = 1'b1;
			ctrl.memWrite = 1'b1;
		end
		mipsPkg::opBeq, mipsPkg::opBne:
		begin
			ctrl.srcA = instr.i.rs;
			ctrl.srcB = instr.i.rt;
			ctrl.br = (instr.i.opcode == mipsPkg::opBeq) ? mipsPkg::brEq : mipsPkg::brNe;
		end
		mipsPkg::opJ: ctrl.jump = 1'b1;
		default: ctrl.jump = 1'b0;
	endcase
end

endmodule

/* logic/alu.sv */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module alu (
	input logic [`MIPS_XLEN-1:0] a,
	input logic [`MIPS_XLEN-1:0] b,
	input mipsPkg::aluOpT op,
	output logic [`MIPS_XLEN-1:0] result
);

localparam int shWidth = $clog2(`MIPS_XLEN);

logic [shWidth-1:0] shAmt;

assign shAmt = a[shWidth-1:0]; // Shift count rides on operand a

always_comb
begin
	case (op)
		mipsPkg::aluAdd: result = a + b;
		mipsPkg::aluSub: result = a - b;
		mipsPkg::aluAnd: result = a & b;
		mipsPkg::aluOr: result = a | b;
		mipsPkg::aluNor: result = ~(a | b);
		mipsPkg::aluXor: result = a ^ b;
		mipsPkg::aluSlt: result = {{(`MIPS_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
		mipsPkg::aluSltu: result = {{(`MIPS_XLEN-1){1'b0}}, a < b};
		mipsPkg::aluSll: result = b << shAmt;
		mipsPkg::aluSrl: result = b >> shAmt;
		mipsPkg::aluSra: result = $signed(b) >>> shAmt; // Keeps the sign bit
		default: result = '0;
	endcase
end

// Decoder must only ever hand over a defined operation
aluOpLegal: assert property (@(op)
	$isunknown(op) || op inside {mipsPkg::aluAdd, mipsPkg::aluSub, mipsPkg::aluAnd,
		mipsPkg::aluOr, mipsPkg::aluNor, mipsPkg::aluXor, mipsPkg::aluSlt,
		mipsPkg::aluSltu, mipsPkg::aluSll, mipsPkg::aluSrl, mipsPkg::aluSra})
	else $error("alu: illegal operation code %0d", op);

endmodule

/* common/mipsPkg.sv */
`include "mips_cfg.svh"

package mipsPkg;

	typedef enum logic [5:0]
	{
		opRtype = 6'b000000,
		opJ     = 6'b000010,
		opBeq   = 6'b000100,
		opBne   = 6'b000101,
		opAddi  = 6'b001000,
		opSlti  = 6'b001010,
		opAndi  = 6'b001100,
		opOri   = 6'b001101,
		opXori  = 6'b001110,
		opLb    = 6'b100000,
		opSb    = 6'b101000
	} opcodeT;

	typedef enum logic [5:0]
	{
		fnSll  = 6'b000000,
		fnSrl  = 6'b000010,
		fnSra  = 6'b000011,
		fnSllv = 6'b000100,
		fnSrlv = 6'b000110,
		fnSrav = 6'b000111,
		fnAdd  = 6'b100000,
		fnSub  = 6'b100010,
		fnAnd  = 6'b100100,
		fnOr   = 6'b100101,
		fnXor  = 6'b100110,
		fnNor  = 6'b100111,
		fnSlt  = 6'b101010,
		fnSltu = 6'b101011
	} functT;

	typedef enum logic [3:0]
	{
		aluAdd, aluSub, aluAnd, aluOr, aluNor, aluXor,
		aluSlt, aluSltu, aluSll, aluSrl, aluSra
	} aluOpT;

	typedef enum logic [1:0] {brNone, brEq, brNe} brT;

	// Readback source selected by the debug port
	typedef enum logic [1:0] {rdReg, rdPc, rdDmem, rdStatus} readSelT;

	typedef struct packed
	{
		opcodeT opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		functT funct;
	} rFormatT;

	typedef struct packed
	{
		opcodeT opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm16;
	} iFormatT;

	typedef struct packed
	{
		opcodeT opcode;
		logic [25:0] target26;
	} jFormatT;

	typedef union packed
	{
		rFormatT r;
		iFormatT i;
		jFormatT j;
	} instrT;

	typedef struct packed
	{
		aluOpT aluOp;
		logic [`MIPS_REG_AW-1:0] srcA;
		logic [`MIPS_REG_AW-1:0] srcB;
		logic [`MIPS_REG_AW-1:0] dest;
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic immSigned;
		logic useImm;
		logic useShamt;
		brT br;
		logic jump;
	} ctrlT;

	typedef struct packed
	{
		logic imemWe;
		logic regWe;
		logic pcWe;
		logic dmemWe;
		logic stepStart;
		logic [$clog2(`MIPS_IMEM_WORDS)-1:0] index;
		logic [`MIPS_XLEN-1:0] wdata;
	} dbgReqT;

endpackage

/* common/mips_cfg.svh */
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// Core widths
`define MIPS_XLEN        32
`define MIPS_REG_COUNT   32
`define MIPS_REG_AW      5

// Memory depths
`define MIPS_IMEM_WORDS  128
`define MIPS_DMEM_BYTES  128

// Debug port address map, byte addresses
`define MIPS_APB_AW      12
`define MIPS_ADDR_IMEM   12'h000
`define MIPS_ADDR_REGS   12'h200
`define MIPS_ADDR_PC     12'h280
`define MIPS_ADDR_STEP   12'h284
`define MIPS_ADDR_STATUS 12'h288
`define MIPS_ADDR_DMEM   12'h300

`endif
